// File: logic/axi_pkg.sv
package axi_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int LEN_W = 4;
    localparam int RESP_W = 2;
    localparam int STRB_W = DATA_W / 8;

    // byte offset bits inside one data word
    localparam int BYTE_OFF_W = $clog2(STRB_W);

    // bursts increment only inside a 4 KB page
    localparam int PAGE_W = 12;

    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

// File: logic/wb_pkg.sv
package wb_pkg;

    // cycle type tags
    localparam int CTI_W = 3;
    localparam logic [CTI_W-1:0] CTI_INCR = 3'b010;
    localparam logic [CTI_W-1:0] CTI_END = 3'b111;

    // bridge buffering
    localparam int CMD_FIFO_DEPTH = 12;
    localparam int RESP_FIFO_DEPTH = 16;
    // leaves room for every beat still in flight
    localparam int RESP_ALMOST_FULL = 12;

    // memory slave layout
    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

    // error window 0x800 .. 0x8ff
    localparam logic [31:0] ERR_BASE = 32'h0000_0800;
    localparam int ERR_SPAN_W = 8;

endpackage

// File: logic/rvh_decoupler.sv
`timescale 1ns/1ps

module rvh_decoupler #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid_i,
    input  logic [WIDTH-1:0] in_data_i,
    output logic             in_ready_o,
    input  logic             out_ready_i,
    output logic             out_valid_o,
    output logic [WIDTH-1:0] out_data_o
);

    logic             valid_q;
    logic             ready_q;
    logic [WIDTH-1:0] data_q;
    logic             take;
    logic             valid_next;

    assign take = in_valid_i && ready_q;
    assign valid_next = take || (valid_q && !out_ready_i);

    // ready is a register, so nothing downstream reaches the input side
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            valid_q <= valid_next;
            ready_q <= !valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= in_data_i;
        end
    end

    assign in_ready_o = ready_q;
    assign out_valid_o = valid_q;
    assign out_data_o = data_q;

endmodule

// File: logic/fifo_shiftreg.sv
`timescale 1ns/1ps

module fifo_shiftreg #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4,
    parameter int ALMOST_FULL = DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o,
    output logic             full_o,
    output logic             almost_full_o
);

    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [CNT_W-1:0] cnt_q;
    logic [IDX_W-1:0] rd_idx;
    logic             do_push;
    logic             do_pop;

    assign do_pop = pop_i && !empty_o;
    // a full FIFO still takes a push when the oldest entry leaves
    assign do_push = push_i && (!full_o || do_pop);

    // new entries enter at 0, oldest sits at cnt-1
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[0] <= push_data_i;
            for (int i = 1; i < DEPTH; i++) begin
                mem[i] <= mem[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (do_push && !do_pop) begin
            cnt_q <= cnt_q + CNT_W'(1);
        end else if (do_pop && !do_push) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    assign rd_idx = empty_o ? '0 : IDX_W'(cnt_q - CNT_W'(1));
    assign pop_data_o = mem[rd_idx];

    assign empty_o = (cnt_q == '0);
    assign full_o = (cnt_q == CNT_W'(DEPTH));
    assign almost_full_o = (cnt_q >= CNT_W'(ALMOST_FULL));

endmodule

// File: logic/axi_to_wb.sv
`timescale 1ns/1ps

module axi_to_wb
    import axi_pkg::*;
    import wb_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              ar_valid_i,
    input  logic [ADDR_W-1:0] ar_addr_i,
    input  logic [LEN_W-1:0]  ar_len_i,
    output logic              ar_ready_o,

    input  logic              aw_valid_i,
    input  logic [ADDR_W-1:0] aw_addr_i,
    input  logic [LEN_W-1:0]  aw_len_i,
    output logic              aw_ready_o,

    input  logic              w_valid_i,
    input  logic              w_last_i,
    input  logic [DATA_W-1:0] w_data_i,
    input  logic [STRB_W-1:0] w_strb_i,
    output logic              w_ready_o,

    input  logic              r_ready_i,
    output logic              r_valid_o,
    output logic              r_last_o,
    output logic [DATA_W-1:0] r_data_o,
    output logic [RESP_W-1:0] r_resp_o,

    input  logic              b_ready_i,
    output logic              b_valid_o,
    output logic [RESP_W-1:0] b_resp_o,

    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [CTI_W-1:0]  wb_cti_o,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic [STRB_W-1:0] wb_sel_o,
    input  logic              wb_ack_i,
    input  logic              wb_err_i,
    input  logic [DATA_W-1:0] wb_dat_i
);

    localparam int RSP_W = DATA_W + RESP_W + 2;

    // write data slice
    logic              w_valid_r;
    logic              w_ready_r;
    logic              w_last_r;
    logic [DATA_W-1:0] w_data_r;
    logic [STRB_W-1:0] w_strb_r;

    rvh_decoupler #(
        .WIDTH (DATA_W + STRB_W + 1)
    ) w_slice (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (w_valid_i),
        .in_data_i   ({w_last_i, w_data_i, w_strb_i}),
        .in_ready_o  (w_ready_o),
        .out_ready_i (w_ready_r),
        .out_valid_o (w_valid_r),
        .out_data_o  ({w_last_r, w_data_r, w_strb_r})
    );

    // command register whose cmd_wr_q also keeps the last direction
    logic              cmd_valid_q;
    logic              cmd_wr_q;
    logic [ADDR_W-1:0] cmd_addr_q;
    logic [LEN_W-1:0]  cmd_len_q;
    logic              cmd_ready;

    assign ar_ready_o = !cmd_valid_q && ar_valid_i && (!aw_valid_i || cmd_wr_q);
    assign aw_ready_o = !cmd_valid_q && aw_valid_i && (!ar_valid_i || !cmd_wr_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid_q <= 1'b0;
            cmd_wr_q <= 1'b0;
        end else if (ar_ready_o) begin
            cmd_valid_q <= 1'b1;
            cmd_wr_q <= 1'b0;
        end else if (aw_ready_o) begin
            cmd_valid_q <= 1'b1;
            cmd_wr_q <= 1'b1;
        end else if (cmd_ready) begin
            cmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_ready_o) begin
            cmd_addr_q <= ar_addr_i;
            cmd_len_q <= ar_len_i;
        end else if (aw_ready_o) begin
            cmd_addr_q <= aw_addr_i;
            cmd_len_q <= aw_len_i;
        end
    end

    // beat generation
    logic              beat_last_q;
    logic [LEN_W-1:0]  beat_cnt_q;
    logic              beat_done;
    logic              stall;
    logic              next_ready;
    logic              issue;
    logic              nxt_valid;
    logic              nxt_we;
    logic [ADDR_W-1:0] nxt_adr;
    logic [LEN_W-1:0]  nxt_cnt;
    logic              cnt_end;
    logic              nxt_last;
    logic [CTI_W-1:0]  nxt_cti;
    logic [STRB_W-1:0] nxt_sel;

    assign beat_done = wb_stb_o && (wb_ack_i || wb_err_i);
    assign next_ready = !stall && (!wb_stb_o || beat_done);
    assign issue = next_ready && nxt_valid;

    always_comb begin
        if (beat_last_q) begin
            // start of a new burst
            nxt_we = cmd_wr_q;
            nxt_adr = cmd_addr_q;
            nxt_cnt = cmd_len_q;
            cnt_end = (cmd_len_q == '0);
            nxt_valid = cmd_valid_q && (w_valid_r || !cmd_wr_q);
            cmd_ready = next_ready && nxt_valid;
        end else begin
            nxt_we = wb_we_o;
            nxt_adr = {wb_adr_o[ADDR_W-1:PAGE_W], wb_adr_o[PAGE_W-1:0] + PAGE_W'(STRB_W)};
            nxt_cnt = beat_cnt_q - LEN_W'(1);
            cnt_end = (beat_cnt_q == LEN_W'(1));
            nxt_valid = w_valid_r || !wb_we_o;
            cmd_ready = 1'b0;
        end
        // an early w_last closes the write burst
        nxt_last = cnt_end || (nxt_we && w_last_r);
        nxt_cti = nxt_last ? CTI_END : CTI_INCR;
        nxt_sel = nxt_we ? w_strb_r : '1;
        w_ready_r = issue && nxt_we;
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wb_we_o <= nxt_we;
            wb_adr_o <= nxt_adr;
            wb_cti_o <= nxt_cti;
            wb_dat_o <= w_data_r;
            wb_sel_o <= nxt_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_last_q <= 1'b1;
            beat_cnt_q <= '0;
            wb_stb_o <= 1'b0;
        end else begin
            if (issue) begin
                beat_last_q <= nxt_last;
                beat_cnt_q <= nxt_cnt;
            end
            if (next_ready) begin
                wb_stb_o <= nxt_valid;
            end else if (beat_done) begin
                wb_stb_o <= 1'b0;
            end
        end
    end

    // command tracking
    logic trk_wr;
    logic trk_last;
    logic trk_empty;

    fifo_shiftreg #(
        .WIDTH (2),
        .DEPTH (CMD_FIFO_DEPTH)
    ) cmd_fifo (
        .clk           (clk),
        .rst           (rst),
        .push_i        (issue),
        .push_data_i   ({nxt_we, nxt_last}),
        .pop_i         (beat_done),
        .pop_data_o    ({trk_wr, trk_last}),
        .empty_o       (trk_empty),
        .full_o        (),
        .almost_full_o ()
    );

    assign wb_cyc_o = !trk_empty;

    // sticky error per burst
    logic [RESP_W-1:0] resp_acc_q;
    logic [RESP_W-1:0] resp_next;

    assign resp_next = wb_err_i ? RESP_SLVERR : resp_acc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_acc_q <= RESP_OKAY;
        end else if (beat_done) begin
            resp_acc_q <= trk_last ? RESP_OKAY : resp_next;
        end
    end

    // response buffering
    logic              rsp_push;
    logic              rsp_pop;
    logic              rsp_empty;
    logic              rsp_afull;
    logic              rsp_wr;
    logic              rsp_last;
    logic [DATA_W-1:0] rsp_data;
    logic [RESP_W-1:0] rsp_resp;

    // writes report once, on the final beat
    assign rsp_push = beat_done && (!trk_wr || trk_last);
    assign rsp_pop = !rsp_empty && (rsp_wr ? (!b_valid_o || b_ready_i)
                                           : (!r_valid_o || r_ready_i));

    fifo_shiftreg #(
        .WIDTH       (RSP_W),
        .DEPTH       (RESP_FIFO_DEPTH),
        .ALMOST_FULL (RESP_ALMOST_FULL)
    ) resp_fifo (
        .clk           (clk),
        .rst           (rst),
        .push_i        (rsp_push),
        .push_data_i   ({wb_dat_i, resp_next, trk_last, trk_wr}),
        .pop_i         (rsp_pop),
        .pop_data_o    ({rsp_data, rsp_resp, rsp_last, rsp_wr}),
        .empty_o       (rsp_empty),
        .full_o        (),
        .almost_full_o (rsp_afull)
    );

    assign stall = rsp_afull;

    // R channel
    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_o <= 1'b0;
        end else if (rsp_pop && !rsp_wr) begin
            r_valid_o <= 1'b1;
        end else if (r_ready_i) begin
            r_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_pop && !rsp_wr) begin
            r_last_o <= rsp_last;
            r_data_o <= rsp_data;
            r_resp_o <= rsp_resp;
        end
    end

    // B channel
    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid_o <= 1'b0;
        end else if (rsp_pop && rsp_wr) begin
            b_valid_o <= 1'b1;
        end else if (b_ready_i) begin
            b_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_pop && rsp_wr) begin
            b_resp_o <= rsp_resp;
        end
    end

endmodule

// File: logic/wb_ram_slave.sv
`timescale 1ns/1ps

module wb_ram_slave
    import axi_pkg::*;
    import wb_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [STRB_W-1:0] wb_sel_i,
    output logic              wb_ack_o,
    output logic              wb_err_o,
    output logic [DATA_W-1:0] wb_dat_o
);

    logic [DATA_W-1:0]     mem [MEM_WORDS];
    logic [MEM_ADDR_W-1:0] word_idx;
    logic                  in_err;
    logic                  take;
    logic                  ack_q;
    logic                  err_q;
    logic [DATA_W-1:0]     rd_q;

    // one answer per strobe, never on the answer cycle itself
    assign take = wb_cyc_i && wb_stb_i && !ack_q && !err_q;

    assign in_err = (wb_adr_i[ADDR_W-1:ERR_SPAN_W] == ERR_BASE[ADDR_W-1:ERR_SPAN_W]);
    // wraps modulo the memory size
    assign word_idx = wb_adr_i[BYTE_OFF_W +: MEM_ADDR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= take && !in_err;
            err_q <= take && in_err;
        end
    end

    always_ff @(posedge clk) begin
        if (take && wb_we_i && !in_err) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wb_sel_i[i]) begin
                    mem[word_idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rd_q <= mem[word_idx];
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_err_o = err_q;
    assign wb_dat_o = rd_q;

endmodule

// File: logic/axi_wb_sys.sv
`timescale 1ns/1ps

module axi_wb_sys
    import axi_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              ar_valid_i,
    input  logic [ADDR_W-1:0] ar_addr_i,
    input  logic [LEN_W-1:0]  ar_len_i,
    output logic              ar_ready_o,

    input  logic              aw_valid_i,
    input  logic [ADDR_W-1:0] aw_addr_i,
    input  logic [LEN_W-1:0]  aw_len_i,
    output logic              aw_ready_o,

    input  logic              w_valid_i,
    input  logic              w_last_i,
    input  logic [DATA_W-1:0] w_data_i,
    input  logic [STRB_W-1:0] w_strb_i,
    output logic              w_ready_o,

    input  logic              r_ready_i,
    output logic              r_valid_o,
    output logic              r_last_o,
    output logic [DATA_W-1:0] r_data_o,
    output logic [RESP_W-1:0] r_resp_o,

    input  logic              b_ready_i,
    output logic              b_valid_o,
    output logic [RESP_W-1:0] b_resp_o
);

    // internal wishbone bus
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [STRB_W-1:0] wb_sel;
    logic              wb_ack;
    logic              wb_err;
    logic [DATA_W-1:0] wb_dat_r;

    axi_to_wb bridge (
        .clk        (clk),
        .rst        (rst),
        .ar_valid_i (ar_valid_i),
        .ar_addr_i  (ar_addr_i),
        .ar_len_i   (ar_len_i),
        .ar_ready_o (ar_ready_o),
        .aw_valid_i (aw_valid_i),
        .aw_addr_i  (aw_addr_i),
        .aw_len_i   (aw_len_i),
        .aw_ready_o (aw_ready_o),
        .w_valid_i  (w_valid_i),
        .w_last_i   (w_last_i),
        .w_data_i   (w_data_i),
        .w_strb_i   (w_strb_i),
        .w_ready_o  (w_ready_o),
        .r_ready_i  (r_ready_i),
        .r_valid_o  (r_valid_o),
        .r_last_o   (r_last_o),
        .r_data_o   (r_data_o),
        .r_resp_o   (r_resp_o),
        .b_ready_i  (b_ready_i),
        .b_valid_o  (b_valid_o),
        .b_resp_o   (b_resp_o),
        .wb_cyc_o   (wb_cyc),
        .wb_stb_o   (wb_stb),
        .wb_we_o    (wb_we),
        .wb_adr_o   (wb_adr),
        // the memory treats every beat alike
        .wb_cti_o   (),
        .wb_dat_o   (wb_dat_w),
        .wb_sel_o   (wb_sel),
        .wb_ack_i   (wb_ack),
        .wb_err_i   (wb_err),
        .wb_dat_i   (wb_dat_r)
    );

    wb_ram_slave memory (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err),
        .wb_dat_o (wb_dat_r)
    );

endmodule

// File: tests/axi_wb_sys_tb.sv
`timescale 1ns/1ps

module axi_wb_sys_tb
    import axi_pkg::*;
();

    localparam int REC_W = 16;
    localparam int MAX_RECS = 16;
    localparam int TIMEOUT = 2000;
    localparam int OP_WRITE = 0;
    localparam int OP_PAIR = 2;

    logic              clk;
    logic              rst;
    logic              ar_valid_i;
    logic [ADDR_W-1:0] ar_addr_i;
    logic [LEN_W-1:0]  ar_len_i;
    logic              ar_ready_o;
    logic              aw_valid_i;
    logic [ADDR_W-1:0] aw_addr_i;
    logic [LEN_W-1:0]  aw_len_i;
    logic              aw_ready_o;
    logic              w_valid_i;
    logic              w_last_i;
    logic [DATA_W-1:0] w_data_i;
    logic [STRB_W-1:0] w_strb_i;
    logic              w_ready_o;
    logic              r_ready_i;
    logic              r_valid_o;
    logic              r_last_o;
    logic [DATA_W-1:0] r_data_o;
    logic [RESP_W-1:0] r_resp_o;
    logic              b_ready_i;
    logic              b_valid_o;
    logic [RESP_W-1:0] b_resp_o;

    logic [31:0]       gold [REC_W*MAX_RECS];
    logic [DATA_W-1:0] r_data_q [$];
    logic [RESP_W-1:0] r_resp_q [$];
    logic              r_last_q [$];
    logic [RESP_W-1:0] b_resp_q [$];
    logic [ADDR_W-1:0] beat_adr_q [$];
    int                r_bursts;
    int                errors;
    int                test_errs;
    int                cur_test;
    logic              hung;
    integer            seed;

    axi_wb_sys UUT (
        .clk        (clk),
        .rst        (rst),
        .ar_valid_i (ar_valid_i),
        .ar_addr_i  (ar_addr_i),
        .ar_len_i   (ar_len_i),
        .ar_ready_o (ar_ready_o),
        .aw_valid_i (aw_valid_i),
        .aw_addr_i  (aw_addr_i),
        .aw_len_i   (aw_len_i),
        .aw_ready_o (aw_ready_o),
        .w_valid_i  (w_valid_i),
        .w_last_i   (w_last_i),
        .w_data_i   (w_data_i),
        .w_strb_i   (w_strb_i),
        .w_ready_o  (w_ready_o),
        .r_ready_i  (r_ready_i),
        .r_valid_o  (r_valid_o),
        .r_last_o   (r_last_o),
        .r_data_o   (r_data_o),
        .r_resp_o   (r_resp_o),
        .b_ready_i  (b_ready_i),
        .b_valid_o  (b_valid_o),
        .b_resp_o   (b_resp_o)
    );

    always #5 clk = ~clk;

    // new ready values first, then capture beats that transfer at the next rising edge
    always @(negedge clk) begin
        r_ready_i = (($random(seed) & 3) != 0);
        b_ready_i = (($random(seed) & 1) != 0);
        if (r_valid_o && r_ready_i) begin
            r_data_q.push_back(r_data_o);
            r_resp_q.push_back(r_resp_o);
            r_last_q.push_back(r_last_o);
            if (r_last_o) begin
                r_bursts++;
            end
        end
        if (b_valid_o && b_ready_i) begin
            b_resp_q.push_back(b_resp_o);
        end
    end

    // wishbone beat addresses, taken before the edge that completes each beat
    always @(negedge clk) begin
        if (UUT.wb_stb && (UUT.wb_ack || UUT.wb_err)) begin
            beat_adr_q.push_back(UUT.wb_adr);
        end
    end

    function automatic string test_name(input int num);
        case (num)
            1: return "single_beat";
            2: return "burst4";
            3: return "partial_strobe";
            4: return "error_window";
            5: return "page_wrap";
            6: return "overlap";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s %s: expected %h, actual %h", test_name(cur_test), what, exp, act);
        errors++;
        test_errs++;
    endtask

    task automatic issue_cmd(input logic is_wr, input logic [ADDR_W-1:0] addr,
                             input logic [LEN_W-1:0] len);
        int   n;
        logic rdy;
        n = 0;
        if (is_wr) begin
            aw_valid_i = 1'b1;
            aw_addr_i = addr;
            aw_len_i = len;
        end else begin
            ar_valid_i = 1'b1;
            ar_addr_i = addr;
            ar_len_i = len;
        end
        #1;
        rdy = is_wr ? aw_ready_o : ar_ready_o;
        while (!rdy && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            rdy = is_wr ? aw_ready_o : ar_ready_o;
            n++;
        end
        if (!rdy) begin
            $display("%s command at %h was never accepted", is_wr ? "write" : "read", addr);
            hung = 1'b1;
        end
        @(negedge clk);
        if (is_wr) begin
            aw_valid_i = 1'b0;
        end else begin
            ar_valid_i = 1'b0;
        end
    endtask

    task automatic drive_w_beats(input int base);
        int n;
        int gap;
        int beats;
        beats = gold[base+3] + 1;
        for (int i = 0; i < beats && !hung; i++) begin
            gap = $random(seed) & 3;
            w_valid_i = 1'b0;
            repeat (gap) @(negedge clk);
            w_valid_i = 1'b1;
            w_data_i = gold[base+4+i];
            w_strb_i = gold[base+8+i][STRB_W-1:0];
            w_last_i = (i == beats - 1);
            n = 0;
            #1;
            while (!w_ready_o && n < TIMEOUT) begin
                @(negedge clk);
                #1;
                n++;
            end
            if (!w_ready_o) begin
                $display("write data beat %0d was never accepted", i);
                hung = 1'b1;
            end
            @(negedge clk);
        end
        w_valid_i = 1'b0;
        w_last_i = 1'b0;
    endtask

    task automatic collect_b(input int base);
        int n;
        n = 0;
        @(posedge clk);
        while (b_resp_q.size() == 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (b_resp_q.size() == 0) begin
            $display("no write response for the burst at %h", gold[base+2]);
            hung = 1'b1;
        end else begin
            report_check_b(base, b_resp_q.pop_front());
        end
    endtask

    task automatic report_check_b(input int base, input logic [RESP_W-1:0] got);
        if (got !== gold[base+12][RESP_W-1:0]) begin
            report_mismatch("b_resp", gold[base+12], 32'(got));
        end
    endtask

    task automatic collect_r(input int base);
        int                n;
        int                beats;
        int                got;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        logic [RESP_W-1:0] exp_resp;
        logic              last;
        n = 0;
        beats = gold[base+3] + 1;
        @(posedge clk);
        while (r_bursts == 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (r_bursts == 0) begin
            $display("read burst at %h never finished", gold[base+2]);
            hung = 1'b1;
        end else begin
            r_bursts--;
            got = 0;
            last = 1'b0;
            while (!last) begin
                data = r_data_q.pop_front();
                resp = r_resp_q.pop_front();
                last = r_last_q.pop_front();
                // data on error beats carries no meaning
                if (got < 4) begin
                    exp_resp = RESP_W'(gold[base+13] >> (2 * got));
                    if (resp !== exp_resp) begin
                        report_mismatch($sformatf("r_resp beat %0d", got), 32'(exp_resp),
                                        32'(resp));
                    end
                    if (exp_resp == RESP_OKAY && data !== gold[base+4+got]) begin
                        report_mismatch($sformatf("r_data beat %0d", got), gold[base+4+got], data);
                    end
                end
                got++;
            end
            if (got != beats) begin
                report_mismatch("r beat count", beats, got);
            end
        end
    endtask

    // beat i sits four bytes per beat above the start, inside the start's 4 KB page
    task automatic check_beat_addrs(input int base);
        int                beats;
        logic [ADDR_W-1:0] start;
        logic [ADDR_W-1:0] exp_adr;
        beats = gold[base+3] + 1;
        start = gold[base+2];
        if (beat_adr_q.size() != beats) begin
            report_mismatch("wishbone beat count", beats, beat_adr_q.size());
        end else begin
            for (int i = 0; i < beats; i++) begin
                exp_adr = (start & ~32'hfff) | ((start + 4 * i) & 32'hfff);
                if (beat_adr_q[i] !== exp_adr) begin
                    report_mismatch($sformatf("beat %0d address", i), exp_adr, beat_adr_q[i]);
                end
            end
        end
        beat_adr_q.delete();
    endtask

    task automatic run_single(input int base);
        @(negedge clk);
        beat_adr_q.delete();
        if (gold[base+1] == OP_WRITE) begin
            fork
                issue_cmd(1'b1, gold[base+2], gold[base+3][LEN_W-1:0]);
                drive_w_beats(base);
            join
            collect_b(base);
        end else begin
            issue_cmd(1'b0, gold[base+2], gold[base+3][LEN_W-1:0]);
            collect_r(base);
        end
        if (!hung) begin
            check_beat_addrs(base);
        end
    endtask

    // write and read commands raised on the same edge
    task automatic run_pair(input int wbase, input int rbase);
        @(negedge clk);
        fork
            begin
                fork
                    issue_cmd(1'b1, gold[wbase+2], gold[wbase+3][LEN_W-1:0]);
                    drive_w_beats(wbase);
                join
                collect_b(wbase);
            end
            begin
                issue_cmd(1'b0, gold[rbase+2], gold[rbase+3][LEN_W-1:0]);
                collect_r(rbase);
            end
        join
    endtask

    initial begin
        int rec;
        int base;
        int tests_run;
        int tests_bad;
        clk = 1'b0;
        rst = 1'b1;
        ar_valid_i = 1'b0;
        ar_addr_i = '0;
        ar_len_i = '0;
        aw_valid_i = 1'b0;
        aw_addr_i = '0;
        aw_len_i = '0;
        w_valid_i = 1'b0;
        w_last_i = 1'b0;
        w_data_i = '0;
        w_strb_i = '0;
        r_ready_i = 1'b0;
        b_ready_i = 1'b0;
        seed = 69671;
        r_bursts = 0;
        errors = 0;
        test_errs = 0;
        cur_test = 0;
        hung = 1'b0;
        tests_run = 0;
        tests_bad = 0;
        for (int i = 0; i < REC_W * MAX_RECS; i++) begin
            gold[i] = '0;
        end
        $readmemh("tests/axi_wb_golden.txt", gold);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        rec = 0;
        while (rec < MAX_RECS && gold[rec*REC_W] != 0 && !hung) begin
            base = rec * REC_W;
            cur_test = gold[base];
            if (gold[base+1] == OP_PAIR) begin
                run_pair(base, base + REC_W);
                rec += 2;
            end else begin
                run_single(base);
                rec += 1;
            end
            // a test ends where the next record has another number
            if (rec >= MAX_RECS || gold[rec*REC_W] != cur_test || hung) begin
                $display("test %0d %s: %s", cur_test, test_name(cur_test),
                         (test_errs == 0 && !hung) ? "ok" : "failed");
                tests_run++;
                if (test_errs != 0 || hung) begin
                    tests_bad++;
                end
                test_errs = 0;
            end
        end

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_bad, errors);
        if (errors == 0 && !hung && tests_run > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: axi_wb_sys.f
logic/axi_pkg.sv
logic/wb_pkg.sv
logic/rvh_decoupler.sv
logic/fifo_shiftreg.sv
logic/axi_to_wb.sv
logic/wb_ram_slave.sv
logic/axi_wb_sys.sv
tests/axi_wb_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module axi_wb_sys_tb -f axi_wb_sys.f --Mdir obj_dir
out=$(./obj_dir/Vaxi_wb_sys_tb)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// File: tests/axi_wb_golden.txt
// line 1: test op addr len data0 data1 data2 data3 (data is expected read data for reads)
// line 2: strb0 strb1 strb2 strb3 b_resp r_resp 0 0 (r_resp packs 2 bits per beat, beat 0 lowest)
// op 0 write, 1 read, 2 write issued together with the read that follows
1 0 00000100 0 11223344 0 0 0
f 0 0 0 0 0 0 0
1 1 00000100 0 11223344 0 0 0
0 0 0 0 0 0 0 0
2 0 00000200 3 a0000001 a0000002 a0000003 a0000004
f f f f 0 0 0 0
2 1 00000200 3 a0000001 a0000002 a0000003 a0000004
0 0 0 0 0 0 0 0
3 0 00000300 0 aabbccdd 0 0 0
f 0 0 0 0 0 0 0
3 0 00000300 0 11223344 0 0 0
5 0 0 0 0 0 0 0
3 1 00000300 0 aa22cc44 0 0 0
0 0 0 0 0 0 0 0
4 0 000007f8 3 b0000001 b0000002 b0000003 b0000004
f f f f 2 0 0 0
4 1 000007f8 3 b0000001 b0000002 0 0
0 0 0 0 0 a0 0 0
5 0 00000ffc 1 c0000001 c0000002 0 0
f f 0 0 0 0 0 0
5 1 00000000 0 c0000002 0 0 0
0 0 0 0 0 0 0 0
5 1 00000ffc 1 c0000001 c0000002 0 0
0 0 0 0 0 0 0 0
6 2 00000540 3 d0000001 d0000002 d0000003 d0000004
f f f f 0 0 0 0
6 1 00000200 3 a0000001 a0000002 a0000003 a0000004
0 0 0 0 0 0 0 0
6 1 00000540 3 d0000001 d0000002 d0000003 d0000004
0 0 0 0 0 0 0 0
